// File: src.f
+incdir+bench
rtl/rvv_arch_pkg.sv
rtl/shift_unit_pkg.sv
rtl/shift_decode.sv
rtl/shift_execute.sv
rtl/shift_result.sv
rtl/shift_unit.sv
bench/shift_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= shift_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/shift_model.svh
`ifndef SHIFT_MODEL_SVH
`define SHIFT_MODEL_SVH

// 32-bit xorshift, taps 13/17/5
function automatic logic [31:0] xorshift32(logic [31:0] s);
  logic [31:0] v;
  v = s;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

// expected destination vector of an accepted shift micro-op
function automatic logic [VLEN-1:0] shift_model(alu_uop_t u);
  int unsigned     w;
  int unsigned     n;
  logic [31:0]     mask;
  logic [31:0]     x;
  logic [31:0]     xs;
  logic [31:0]     src;
  logic [31:0]     q;
  logic            r;
  logic            below;
  logic            any;
  logic [VLEN-1:0] res;
  res = '0;
  case (u.vs2_eew)
    EEW8:    w = 8;
    EEW16:   w = 16;
    default: w = 32;
  endcase
  mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
  for (int e = 0; e < VLEN / w; e++) begin
    x   = 32'(u.vs2_data >> (e * w)) & mask;
    src = (u.funct3 == OPIVV) ? 32'(u.vs1_data >> (e * w)) : u.rs1_data;
    n   = src & (w - 1);
    if (u.funct6 == VSLL) begin
      q = (x << n) & mask;
    end else if (u.funct6 == VSRA || u.funct6 == VSSRA) begin
      // sign extend to 32 bits first
      xs = x | (x[w-1] ? ~mask : 32'h0);
      q  = $unsigned($signed(xs) >>> n) & mask;
    end else begin
      q = x >> n;
    end
    r = 1'b0;
    if ((u.funct6 == VSSRL || u.funct6 == VSSRA) && n != 0) begin
      below = (n > 1) ? ((x & ((32'd1 << (n - 1)) - 32'd1)) != 0) : 1'b0;
      any   = (x & ((32'd1 << n) - 32'd1)) != 0;
      case (u.vxrm)
        RNU:     r = x[n-1];
        RNE:     r = x[n-1] & (below | q[0]);
        RDN:     r = 1'b0;
        default: r = !q[0] & any;
      endcase
    end
    res = res | (VLEN'((q + 32'(r)) & mask) << (e * w));
  end
  return res;
endfunction

`endif

// File: bench/shift_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module shift_unit_tb;

  import rvv_arch_pkg::*;
  import shift_unit_pkg::*;

  `include "shift_model.svh"

  localparam int          RESET_CYCLES   = 10;
  localparam int          NUM_CYCLES     = 1000;
  localparam int          TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 20;
  localparam logic [31:0] SEED           = 32'h5df48268;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
    logic [31:0]                due;
  } expect_t;

  logic          clk;
  logic          rst;
  logic          uop_valid;
  alu_uop_t      uop;
  logic          result_valid;
  shift_result_t result;

  logic [31:0]                rng;
  logic [31:0]                cycle = '0;
  logic [ROB_DEPTH_WIDTH-1:0] tag;
  expect_t                    exp_q[$];
  expect_t                    head;
  int                         value_errors;
  int                         unexpected_errors;
  int                         missing_errors;
  int                         protocol_errors;
  int                         drain_wait;

  shift_unit shift_unit_i (
    .clk          (clk),
    .rst          (rst),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 32'd1;

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic is_shift_funct6(logic [5:0] f);
    return f inside {VSLL, VSRL, VSRA, VSSRL, VSSRA};
  endfunction

  function automatic logic accepted(logic v, alu_uop_t u);
    logic f3_ok;
    logic src_ok;
    f3_ok  = (u.funct3 == OPIVV) || (u.funct3 == OPIVI) || (u.funct3 == OPIVX);
    src_ok = (u.funct3 == OPIVV) ? u.vs1_data_valid : u.rs1_data_valid;
    return v && f3_ok && is_shift_funct6(u.funct6) && u.vs2_data_valid && src_ok;
  endfunction

  task automatic drive_uop();
    logic [31:0] r;
    logic [5:0]  f6;
    logic [2:0]  f3;
    expect_t     item;
    r = next_rand();
    uop_valid     = (r[2:0] != 3'd0);
    uop.rob_entry = tag;
    uop.vxrm      = vxrm_e'(r[9:8]);
    case (next_rand() % 32'd3)
      32'd0:   uop.vs2_eew = EEW8;
      32'd1:   uop.vs2_eew = EEW16;
      default: uop.vs2_eew = EEW32;
    endcase
    case (next_rand() % 32'd5)
      32'd0:   uop.funct6 = VSLL;
      32'd1:   uop.funct6 = VSRL;
      32'd2:   uop.funct6 = VSRA;
      32'd3:   uop.funct6 = VSSRL;
      default: uop.funct6 = VSSRA;
    endcase
    case (next_rand() % 32'd3)
      32'd0:   uop.funct3 = OPIVV;
      32'd1:   uop.funct3 = OPIVI;
      default: uop.funct3 = OPIVX;
    endcase
    for (int i = 0; i < VLEN / 32; i++) begin
      uop.vs1_data[i*32 +: 32] = next_rand();
      uop.vs2_data[i*32 +: 32] = next_rand();
    end
    uop.rs1_data       = next_rand();
    uop.vs1_data_valid = 1'b1;
    uop.vs2_data_valid = 1'b1;
    uop.rs1_data_valid = 1'b1;
    // a few rejects, one cause at a time
    case (next_rand() % 32'd16)
      32'd0: begin
        f6 = r[15:10];
        if (is_shift_funct6(f6)) f6 = 6'b000000;
        uop.funct6         = funct6_e'(f6);
        uop.vs2_data_valid = r[16];
      end
      32'd1: begin
        f3 = r[19:17];
        if (f3 == 3'b000 || f3 == 3'b011 || f3 == 3'b100) f3 = 3'b111;
        uop.funct3 = funct3_e'(f3);
      end
      32'd2: begin
        if (uop.funct3 == OPIVV) uop.vs1_data_valid = 1'b0;
        else uop.rs1_data_valid = 1'b0;
      end
      default: ;
    endcase
    if (accepted(uop_valid, uop)) begin
      item.rob_entry = tag;
      item.w_data    = shift_model(uop);
      item.due       = cycle + 32'd3;
      exp_q.push_back(item);
      tag = tag + 1'b1;
    end
  endtask

  // scoreboard
  always @(posedge clk) begin
    if (result_valid === 1'b1) begin
      assert (exp_q.size() > 0) else begin
        unexpected_errors++;
        $display("unexpected result at %0t: rob_entry %h came with nothing outstanding",
                 $time, result.rob_entry);
      end
      if (exp_q.size() > 0) begin
        head = exp_q.pop_front();
        assert (cycle == head.due) else begin
          protocol_errors++;
          $display("result for rob_entry %h came at cycle %0d instead of cycle %0d",
                   head.rob_entry, cycle, head.due);
        end
        assert (result.rob_entry == head.rob_entry) else begin
          value_errors++;
          $display("[ERROR] %0t result.rob_entry: expected %h, got %h",
                   $time, head.rob_entry, result.rob_entry);
        end
        assert (result.w_data == head.w_data) else begin
          value_errors++;
          $display("[ERROR] %0t result.w_data: expected %h, got %h",
                   $time, head.w_data, result.w_data);
        end
      end
    end
  end

  // pipeline still empty right after reset
  initial begin
    @(negedge rst);
    repeat (3) begin
      @(posedge clk);
      assert (result_valid === 1'b0) else begin
        protocol_errors++;
        $display("result_valid went high within three cycles of reset release at %0t", $time);
      end
    end
  end

  always @(posedge clk) begin
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rng               = SEED;
    rst               = 1'b1;
    uop_valid         = 1'b0;
    uop               = '0;
    tag               = '0;
    value_errors      = 0;
    unexpected_errors = 0;
    missing_errors    = 0;
    protocol_errors   = 0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      assert (result_valid === 1'b0) else begin
        protocol_errors++;
        $display("result_valid not low during reset at %0t", $time);
      end
    end
    rst = 1'b0;
    repeat (NUM_CYCLES) begin
      drive_uop();
      @(negedge clk);
    end
    uop_valid  = 1'b0;
    drain_wait = 0;
    while (exp_q.size() != 0 && drain_wait < 8) begin
      @(posedge clk);
      drain_wait++;
    end
    // catch stray results behind the last one
    repeat (4) @(posedge clk);
    assert (exp_q.size() == 0) else begin
      missing_errors = exp_q.size();
      $display("%0d expected results never arrived, missing results", exp_q.size());
    end
    $display("errors: value %0d, unexpected %0d, missing %0d, protocol %0d",
             value_errors, unexpected_errors, missing_errors, protocol_errors);
    if (value_errors + unexpected_errors + missing_errors + protocol_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/shift_unit.sv
`timescale 1ns/100ps
`default_nettype none

module shift_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          uop_valid,
  input  shift_unit_pkg::alu_uop_t      uop,
  output logic                          result_valid,
  output shift_unit_pkg::shift_result_t result
);

  logic                       dec_valid;
  shift_unit_pkg::shift_dec_t dec;
  logic                       exe_valid;
  shift_unit_pkg::shift_exe_t exe;

  // decode, shift, round; one register each
  shift_decode shift_decode_i (
    .clk       (clk),
    .rst       (rst),
    .uop_valid (uop_valid),
    .uop       (uop),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  shift_execute shift_execute_i (
    .clk       (clk),
    .rst       (rst),
    .dec_valid (dec_valid),
    .dec       (dec),
    .exe_valid (exe_valid),
    .exe       (exe)
  );

  shift_result shift_result_i (
    .clk          (clk),
    .rst          (rst),
    .exe_valid    (exe_valid),
    .exe          (exe),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// File: rtl/shift_result.sv
`timescale 1ns/100ps
`default_nettype none

module shift_result (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          exe_valid,
  input  shift_unit_pkg::shift_exe_t    exe,
  output logic                          result_valid,
  output shift_unit_pkg::shift_result_t result
);

  import rvv_arch_pkg::*;

  logic [VLEN-1:0] w_data_d;

  // rounding add, carry dropped at the element boundary
  always_comb begin
    w_data_d = '0;
    for (int e = 0; e < VLENB; e++) begin
      case (exe.eew)
        EEW8: begin
          w_data_d[e*BYTE_WIDTH +: BYTE_WIDTH] = exe.product[e*BYTE_WIDTH +: BYTE_WIDTH] +
                                                 BYTE_WIDTH'(exe.increment[e]);
        end
        EEW16: if (e % 2 == 0) begin
          w_data_d[e*BYTE_WIDTH +: HWORD_WIDTH] = exe.product[e*BYTE_WIDTH +: HWORD_WIDTH] +
                                                  HWORD_WIDTH'(exe.increment[e]);
        end
        EEW32: if (e % 4 == 0) begin
          w_data_d[e*BYTE_WIDTH +: WORD_WIDTH] = exe.product[e*BYTE_WIDTH +: WORD_WIDTH] +
                                                 WORD_WIDTH'(exe.increment[e]);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_valid) begin
      result.rob_entry <= exe.rob_entry;
      result.w_data    <= w_data_d;
    end
  end

  // back-to-back results only from back-to-back execute strobes
  assert property (@(posedge clk) disable iff (rst)
    (result_valid && $past(result_valid)) |-> ($past(exe_valid, 1) && $past(exe_valid, 2)));

endmodule

`default_nettype wire

// File: rtl/shift_execute.sv
`timescale 1ns/100ps
`default_nettype none

module shift_execute (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        dec_valid,
  input  shift_unit_pkg::shift_dec_t  dec,
  output logic                        exe_valid,
  output shift_unit_pkg::shift_exe_t  exe
);

  import rvv_arch_pkg::*;
  import shift_unit_pkg::*;

  logic [VLENB-1:0][2*WORD_WIDTH-1:0]   sh8;
  logic [VLENB/2-1:0][2*WORD_WIDTH-1:0] sh16;
  logic [VLENB/4-1:0][2*WORD_WIDTH-1:0] sh32;
  shift_exe_t                           exe_d;

  // returns {shifted, shifted-out}; shifted-out bits are left aligned
  function automatic logic [2*WORD_WIDTH-1:0] f_shift(shift_op_e op, eew_e eew,
                                                     logic [WORD_WIDTH-1:0] x,
                                                     logic [SHAMT_WIDTH-1:0] n);
    logic                         fill;
    logic [WORD_WIDTH-1:0]        ext;
    logic signed [2*WORD_WIDTH:0] src;
    logic signed [2*WORD_WIDTH:0] res;
    case (eew)
      EEW8:    fill = x[BYTE_WIDTH-1];
      EEW16:   fill = x[HWORD_WIDTH-1];
      default: fill = x[WORD_WIDTH-1];
    endcase
    fill = fill & (op == SHIFT_SRA);
    case (eew)
      EEW8:    ext = {{(WORD_WIDTH-BYTE_WIDTH){fill}}, x[BYTE_WIDTH-1:0]};
      EEW16:   ext = {{(WORD_WIDTH-HWORD_WIDTH){fill}}, x[HWORD_WIDTH-1:0]};
      default: ext = x;
    endcase
    src = {fill, ext, {WORD_WIDTH{1'b0}}};
    if (op == SHIFT_SLL) res = src << n;
    else res = src >>> n;
    return res[2*WORD_WIDTH-1:0];
  endfunction

  // n == 0 leaves out all zero, so every mode gives 0
  function automatic logic f_round(vxrm_e mode, logic q_lsb, logic [WORD_WIDTH-1:0] out);
    case (mode)
      RNU:     return out[WORD_WIDTH-1];
      RNE:     return out[WORD_WIDTH-1] & ((out[WORD_WIDTH-2:0] != '0) | q_lsb);
      ROD:     return !q_lsb & (out != '0);
      default: return 1'b0;
    endcase
  endfunction

  always_comb begin
    for (int e = 0; e < VLENB; e++)
      sh8[e] = f_shift(dec.opcode, EEW8, WORD_WIDTH'(dec.src2[e*BYTE_WIDTH +: BYTE_WIDTH]),
                       dec.amount[e]);
    for (int e = 0; e < VLENB/2; e++)
      sh16[e] = f_shift(dec.opcode, EEW16, WORD_WIDTH'(dec.src2[e*HWORD_WIDTH +: HWORD_WIDTH]),
                        dec.amount[2*e]);
    for (int e = 0; e < VLENB/4; e++)
      sh32[e] = f_shift(dec.opcode, EEW32, dec.src2[e*WORD_WIDTH +: WORD_WIDTH],
                        dec.amount[4*e]);
  end

  // width select, increment in the element's lowest lane
  always_comb begin
    exe_d.rob_entry = dec.rob_entry;
    exe_d.eew       = dec.eew;
    exe_d.product   = '0;
    exe_d.increment = '0;
    for (int e = 0; e < VLENB; e++) begin
      case (dec.eew)
        EEW8: begin
          exe_d.product[e*BYTE_WIDTH +: BYTE_WIDTH] = sh8[e][WORD_WIDTH +: BYTE_WIDTH];
          exe_d.increment[e] = f_round(dec.vxrm, sh8[e][WORD_WIDTH], sh8[e][WORD_WIDTH-1:0]);
        end
        EEW16: if (e % 2 == 0) begin
          exe_d.product[e*BYTE_WIDTH +: HWORD_WIDTH] = sh16[e/2][WORD_WIDTH +: HWORD_WIDTH];
          exe_d.increment[e] = f_round(dec.vxrm, sh16[e/2][WORD_WIDTH],
                                       sh16[e/2][WORD_WIDTH-1:0]);
        end
        EEW32: if (e % 4 == 0) begin
          exe_d.product[e*BYTE_WIDTH +: WORD_WIDTH] = sh32[e/4][WORD_WIDTH +: WORD_WIDTH];
          exe_d.increment[e] = f_round(dec.vxrm, sh32[e/4][WORD_WIDTH],
                                       sh32[e/4][WORD_WIDTH-1:0]);
        end
        default: ;
      endcase
    end
    if (!dec.scaling) exe_d.increment = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      exe <= exe_d;
    end
  end

  // plain shifts never round
  assert property (@(posedge clk) disable iff (rst)
    (dec_valid && !dec.scaling) |=> (exe.increment == '0));

endmodule

`default_nettype wire

// File: rtl/shift_decode.sv
`timescale 1ns/100ps
`default_nettype none

module shift_decode (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      uop_valid,
  input  shift_unit_pkg::alu_uop_t  uop,
  output logic                      dec_valid,
  output shift_unit_pkg::shift_dec_t dec
);

  import rvv_arch_pkg::*;
  import shift_unit_pkg::*;

  logic       f6_ok;
  logic       f3_ok;
  logic       amt_src_valid;
  logic       accept;
  shift_dec_t dec_d;

  // funct6 to shift kind
  always_comb begin
    f6_ok         = 1'b0;
    dec_d.opcode  = SHIFT_SLL;
    dec_d.scaling = 1'b0;
    case (uop.funct6)
      VSLL: begin
        f6_ok = 1'b1;
      end
      VSRL: begin
        f6_ok        = 1'b1;
        dec_d.opcode = SHIFT_SRL;
      end
      VSRA: begin
        f6_ok        = 1'b1;
        dec_d.opcode = SHIFT_SRA;
      end
      VSSRL: begin
        f6_ok         = 1'b1;
        dec_d.opcode  = SHIFT_SRL;
        dec_d.scaling = 1'b1;
      end
      VSSRA: begin
        f6_ok         = 1'b1;
        dec_d.opcode  = SHIFT_SRA;
        dec_d.scaling = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    f3_ok         = 1'b0;
    amt_src_valid = 1'b0;
    case (uop.funct3)
      OPIVV: begin
        f3_ok         = 1'b1;
        amt_src_valid = uop.vs1_data_valid;
      end
      OPIVI, OPIVX: begin
        f3_ok         = 1'b1;
        amt_src_valid = uop.rs1_data_valid;
      end
      default: ;
    endcase
  end

  assign accept = uop_valid & f6_ok & f3_ok & amt_src_valid & uop.vs2_data_valid;

  // amount bits always live in the element's low byte
  always_comb begin
    logic [BYTE_WIDTH-1:0] amt_byte;
    dec_d.rob_entry = uop.rob_entry;
    dec_d.eew       = uop.vs2_eew;
    dec_d.vxrm      = uop.vxrm;
    dec_d.src2      = uop.vs2_data;
    for (int b = 0; b < VLENB; b++) begin
      amt_byte = (uop.funct3 == OPIVV) ? uop.vs1_data[b*BYTE_WIDTH +: BYTE_WIDTH]
                                       : uop.rs1_data[BYTE_WIDTH-1:0];
      dec_d.amount[b] = '0;
      case (uop.vs2_eew)
        EEW8:  dec_d.amount[b] = SHAMT_WIDTH'(amt_byte[2:0]);
        EEW16: if (b % 2 == 0) dec_d.amount[b] = SHAMT_WIDTH'(amt_byte[3:0]);
        EEW32: if (b % 4 == 0) dec_d.amount[b] = amt_byte[SHAMT_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= dec_d;
    end
  end

  // issue side must never send a shift without its vector source
  assert property (@(posedge clk) disable iff (rst)
    (uop_valid && f6_ok) |-> uop.vs2_data_valid);

endmodule

`default_nettype wire

// File: rtl/shift_unit_pkg.sv
`default_nettype none

package shift_unit_pkg;

  import rvv_arch_pkg::*;

  // widest element is 32 bits, so 5 amount bits
  localparam int SHAMT_WIDTH = 5;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'd0,
    SHIFT_SRL = 2'd1,
    SHIFT_SRA = 2'd2
  } shift_op_e;

  // micro-op from the ALU reservation station
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    funct6_e                    funct6;
    funct3_e                    funct3;
    vxrm_e                      vxrm;
    logic [VLEN-1:0]            vs1_data;
    logic                       vs1_data_valid;
    logic [VLEN-1:0]            vs2_data;
    logic                       vs2_data_valid;
    eew_e                       vs2_eew;
    logic [XLEN-1:0]            rs1_data;
    logic                       rs1_data_valid;
  } alu_uop_t;

  // amount sits in the lowest byte lane of each element
  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0]             rob_entry;
    shift_op_e                              opcode;
    logic                                   scaling;
    eew_e                                   eew;
    vxrm_e                                  vxrm;
    logic [VLEN-1:0]                        src2;
    logic [VLENB-1:0][SHAMT_WIDTH-1:0]      amount;
  } shift_dec_t;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    eew_e                       eew;
    logic [VLEN-1:0]            product;
    logic [VLENB-1:0]           increment;
  } shift_exe_t;

  typedef struct packed {
    logic [ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [VLEN-1:0]            w_data;
  } shift_result_t;

endpackage

`default_nettype wire

// File: rtl/rvv_arch_pkg.sv
`default_nettype none

package rvv_arch_pkg;

  // vector and scalar register widths
  localparam int VLEN            = 128;
  localparam int VLENB           = VLEN / 8;
  localparam int XLEN            = 32;
  localparam int ROB_DEPTH_WIDTH = 4;

  // element container widths
  localparam int BYTE_WIDTH  = 8;
  localparam int HWORD_WIDTH = 16;
  localparam int WORD_WIDTH  = 32;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  // fixed-point rounding modes, vxrm encoding
  typedef enum logic [1:0] {
    RNU = 2'd0,
    RNE = 2'd1,
    RDN = 2'd2,
    ROD = 2'd3
  } vxrm_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  // integer arithmetic funct6, shift subset only
  typedef enum logic [5:0] {
    VSLL  = 6'b100101,
    VSRL  = 6'b101000,
    VSRA  = 6'b101001,
    VSSRL = 6'b101010,
    VSSRA = 6'b101011
  } funct6_e;

endpackage

`default_nettype wire
